//--- pixel_config.svh
`ifndef PIXEL_CONFIG_SVH
`define PIXEL_CONFIG_SVH

// Matrix geometry
`define COLS        8
`define COL_BITS    3       // Enough to index COLS

// Bunch-crossing counter, also the width of every timestamp
`define BCID_BITS   6

// Output word, column index above the timestamp
`define WORD_BITS   (`COL_BITS + `BCID_BITS)

// Timestamp field while the test pattern is on
`define TEST_STAMP  6'h2A   // Alternating bits, easy to spot on a scope

// Two flags plus column enable and hit-OR select masks
`define CONF_BITS   (2 + 2 * `COLS)

`endif

//--- pixelPkg.sv
`include "pixel_config.svh"

package pixelPkg;

    // Field view of the configuration word, MSB first
    typedef struct packed {
        logic               enTestPattern;  // Fixed stamp in every word
        logic               enReadout;      // Arbiter may pick columns
        logic [`COLS-1:0]   colEnable;      // Per-column hit mask
        logic [`COLS-1:0]   hitOrSel;       // Columns feeding hitOr
    } tConfFields;

    // Same 18 bits seen by the shift path and by the consumers
    typedef union packed {
        tConfFields             fields;
        logic [`CONF_BITS-1:0]  raw;
    } tConf;

    // Power-up setting
    // Readout running on every column, no test pattern, hit-OR quiet
    localparam tConfFields defaultFields = '{
        enTestPattern: 1'b0,
        enReadout:     1'b1,
        colEnable:     {`COLS{1'b1}},
        hitOrSel:      {`COLS{1'b0}}
    };

    localparam tConf defaultConf = tConf'(defaultFields);

endpackage

//--- confRegister.sv
`timescale 1ns/1ps

`include "pixel_config.svh"

module confRegister
    import pixelPkg::*;
(
    input  logic ClkBx,
    input  logic reset_ff,
    input  logic confSi,
    input  logic confShift,
    input  logic confLoad,
    input  logic confDefault,
    output logic confSo,
    output tConf conf
);

    tConf shiftReg;     // Serial side, only seen as raw bits

    // Shift toward the MSB, new bit enters at bit 0
    always_ff @(posedge ClkBx) begin
        if (reset_ff || confDefault) begin
            shiftReg <= defaultConf;
        end else if (confShift) begin
            shiftReg.raw <= {shiftReg.raw[`CONF_BITS-2:0], confSi};
        end
    end

    // Active copy, applies from the cycle after the load
    always_ff @(posedge ClkBx) begin
        if (reset_ff || confDefault) begin
            conf <= defaultConf;
        end else if (confLoad) begin
            conf <= shiftReg;   // Takes the pre-shift value if both strobes hit
        end
    end

    // Readback leaves from the top of the chain
    assign confSo = shiftReg.raw[`CONF_BITS-1];

endmodule

//--- hitCapture.sv
`timescale 1ns/1ps

`include "pixel_config.svh"

module hitCapture
    import pixelPkg::*;
(
    input  logic                                ClkBx,
    input  logic                                reset_ff,
    input  tConf                                conf,
    input  logic                                freeze,
    input  logic [`COLS-1:0]                    hitIn,
    input  logic [`COLS-1:0]                    clearCol,
    output logic [`COLS-1:0]                    pending,
    output logic [`COLS-1:0][`BCID_BITS-1:0]    stamps,
    output logic                                hitOr
);

    logic [`BCID_BITS-1:0]  bcidBin;
    logic [`BCID_BITS-1:0]  bcidGray;
    logic [`COLS-1:0]       capture;

    // Crossing counter, wraps every 64 cycles
    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            bcidBin <= '0;
        end else begin
            bcidBin <= bcidBin + 1'b1;
        end
    end

    // Only one bit changes per crossing
    assign bcidGray = bcidBin ^ (bcidBin >> 1);

    // Enabled, not frozen and the column latch free
    assign capture = hitIn & conf.fields.colEnable & ~pending & {`COLS{~freeze}};

    // A pending column ignores further hits until the arbiter clears it
    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            pending <= '0;
        end else begin
            pending <= (pending & ~clearCol) | capture;
        end
    end

    // Stamp of the sampling edge
    always_ff @(posedge ClkBx) begin
        for (int c = 0; c < `COLS; c++) begin
            if (capture[c]) begin
                stamps[c] <= bcidGray;
            end
        end
    end

    // Fast trigger path, ignores enable and freeze
    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            hitOr <= 1'b0;
        end else begin
            hitOr <= |(hitIn & conf.fields.hitOrSel);
        end
    end

endmodule

//--- readoutArbiter.sv
`timescale 1ns/1ps

`include "pixel_config.svh"

module readoutArbiter
    import pixelPkg::*;
(
    input  logic                                ClkBx,
    input  logic                                reset_ff,
    input  tConf                                conf,
    input  logic [`COLS-1:0]                    pending,
    input  logic [`COLS-1:0][`BCID_BITS-1:0]    stamps,
    input  logic                                dataReady,
    output logic [`COLS-1:0]                    clearCol,
    output logic                                dataValid,
    output logic [`WORD_BITS-1:0]               dataWord,
    output logic                                token
);

    logic [`COLS-1:0]       candidates;
    logic                   found;
    logic [`COL_BITS-1:0]   pickCol;
    logic [`COLS-1:0]       pickOneHot;
    logic [`BCID_BITS-1:0]  stampField;
    logic                   canLoad;
    logic                   load;

    // A column being cleared still shows pending for one more cycle
    assign candidates = pending & ~clearCol;

    // Priority encoder, lowest column wins
    always_comb begin
        found   = 1'b0;
        pickCol = '0;
        for (int c = `COLS - 1; c >= 0; c--) begin
            if (candidates[c]) begin
                found   = 1'b1;
                pickCol = `COL_BITS'(c);
            end
        end
    end

    assign pickOneHot = `COLS'(1) << pickCol;

    // Test pattern replaces only the stamp, column order stays the same
    assign stampField = conf.fields.enTestPattern ? `TEST_STAMP : stamps[pickCol];

    // Output register empty or being taken this edge
    assign canLoad = (~dataValid | dataReady) & conf.fields.enReadout;
    assign load    = canLoad & found;

    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            dataValid <= 1'b0;
            clearCol  <= '0;
        end else begin
            clearCol <= load ? pickOneHot : '0;    // Single-cycle pulse
            if (load) begin
                dataValid <= 1'b1;
            end else if (dataReady) begin
                dataValid <= 1'b0;
            end
        end
    end

    // Word held steady until the transfer
    always_ff @(posedge ClkBx) begin
        if (load) begin
            dataWord <= {pickCol, stampField};
        end
    end

    // Busy while anything is waiting or on the bus
    assign token = (|pending) | dataValid;

endmodule

//--- pixelCore.sv
`timescale 1ns/1ps

`include "pixel_config.svh"

module pixelCore
    import pixelPkg::*;
(
    input  logic                    ClkBx,
    input  logic                    reset_ff,
    // Serial configuration
    input  logic                    confSi,
    input  logic                    confShift,
    input  logic                    confLoad,
    input  logic                    confDefault,
    output logic                    confSo,
    // Front end
    input  logic                    freeze,
    input  logic [`COLS-1:0]        hitIn,
    output logic                    hitOr,
    // Readout bus
    input  logic                    dataReady,
    output logic                    dataValid,
    output logic [`WORD_BITS-1:0]   dataWord,
    output logic                    token
);

    tConf                               conf;
    logic [`COLS-1:0]                   pending;
    logic [`COLS-1:0]                   clearCol;
    logic [`COLS-1:0][`BCID_BITS-1:0]   stamps;

    confRegister confRegisterInst (
        .ClkBx      (ClkBx),
        .reset_ff   (reset_ff),
        .confSi     (confSi),
        .confShift  (confShift),
        .confLoad   (confLoad),
        .confDefault(confDefault),
        .confSo     (confSo),
        .conf       (conf)
    );

    hitCapture hitCaptureInst (
        .ClkBx      (ClkBx),
        .reset_ff   (reset_ff),
        .conf       (conf),
        .freeze     (freeze),
        .hitIn      (hitIn),
        .clearCol   (clearCol),     // Back from the arbiter
        .pending    (pending),
        .stamps     (stamps),
        .hitOr      (hitOr)
    );

    readoutArbiter readoutArbiterInst (
        .ClkBx      (ClkBx),
        .reset_ff   (reset_ff),
        .conf       (conf),
        .pending    (pending),
        .stamps     (stamps),
        .dataReady  (dataReady),
        .clearCol   (clearCol),
        .dataValid  (dataValid),
        .dataWord   (dataWord),
        .token      (token)
    );

endmodule

//--- tbPixelCore.sv
`timescale 1ns/1ps

`include "pixel_config.svh"

module tbPixelCore
    import pixelPkg::*;
();

    localparam int NumTests   = 12;
    localparam int Fields     = 15;    // Values per golden row
    // Shift, load, worst alignment, hold and hitOr edge, then a slow drain
    localparam int TestCycles = `CONF_BITS + 1 + (1 << `BCID_BITS) + 3 + 8 * `COLS;
    localparam int CycleLimit = NumTests * TestCycles + 200;
    localparam logic [31:0] Seed = 32'h8353233a;

    logic                   ClkBx;
    logic                   reset_ff;
    logic                   confSi;
    logic                   confShift;
    logic                   confLoad;
    logic                   confDefault;
    logic                   confSo;
    logic                   freeze;
    logic [`COLS-1:0]       hitIn;
    logic                   hitOr;
    logic                   dataReady;
    logic                   dataValid;
    logic [`WORD_BITS-1:0]  dataWord;
    logic                   token;

    logic [31:0]            golden [0:NumTests*Fields-1];
    logic [`WORD_BITS-1:0]  gotWords [$];   // Every transfer seen on the bus
    logic [31:0]            lcgState;
    int                     cycleCount;
    int                     edgesSinceReset;
    tConf                   lastConf;       // What the shift chain should hold
    tConf                   readBack;
    tConf                   scrambled;

    pixelCore DUT (
        .ClkBx      (ClkBx),
        .reset_ff   (reset_ff),
        .confSi     (confSi),
        .confShift  (confShift),
        .confLoad   (confLoad),
        .confDefault(confDefault),
        .confSo     (confSo),
        .freeze     (freeze),
        .hitIn      (hitIn),
        .hitOr      (hitOr),
        .dataReady  (dataReady),
        .dataValid  (dataValid),
        .dataWord   (dataWord),
        .token      (token)
    );

    initial begin
        ClkBx = 1'b0;
        forever #5 ClkBx = ~ClkBx;
    end

    function automatic logic [31:0] lcgNext(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [`BCID_BITS-1:0] toGray(input logic [`BCID_BITS-1:0] bin);
        return bin ^ (bin >> 1);
    endfunction

    function automatic string testName(input int idx);
        case (idx)
            0:       return "single_col3";
            1:       return "single_col0";
            2:       return "multi_all";
            3:       return "multi_sparse";
            4:       return "masked_cols";
            5:       return "masked_partial";
            6:       return "freeze";
            7:       return "pileup";
            8:       return "test_pattern";
            9:       return "hit_or";
            10:      return "hit_or_quiet";
            11:      return "pattern_masked";
            default: return "unknown";
        endcase
    endfunction

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkWord(input string name, input logic [`WORD_BITS-1:0] expected,
                             input logic [`WORD_BITS-1:0] actual);
        if (actual !== expected) begin
            abortRun($sformatf("** Error: %s word expected %h actual %h",
                               name, expected, actual));
        end
    endtask

    task automatic checkConf(input string name, input tConf expected, input tConf actual);
        if (actual.raw !== expected.raw) begin
            abortRun($sformatf("** Error: %s readback expected %h actual %h",
                               name, expected.raw, actual.raw));
        end
    endtask

    task automatic checkHitOr(input string name, input logic [`COLS-1:0] maskedHits,
                              input logic actual);
        logic expected;
        expected = |maskedHits;
        if (actual !== expected) begin
            abortRun($sformatf("** Error: %s hitOr expected %b actual %b (masked hits %h)",
                               name, expected, actual, maskedHits));
        end
    endtask

    // One clock edge, with bus capture and new back-pressure
    task automatic tick();
        @(posedge ClkBx);
        cycleCount++;
        if (cycleCount > CycleLimit) begin
            abortRun($sformatf("Timeout: no finish after %0d cycles", CycleLimit));
        end
        if (reset_ff) begin
            edgesSinceReset = 0;
        end else begin
            edgesSinceReset++;
        end
        if (dataValid && dataReady) begin
            gotWords.push_back(dataWord);
        end
        lcgState = lcgNext(lcgState);
        dataReady <= (lcgState[17:16] != 2'b00);   // Ready about three edges in four
    endtask

    // Shifts a word in and collects the old chain contents, MSB first
    task automatic shiftConf(input tConf inWord, output tConf outWord);
        tConf captured;
        captured = inWord;
        for (int i = `CONF_BITS - 1; i >= 0; i--) begin
            confSi    <= inWord.raw[i];
            confShift <= 1'b1;
            tick();
            captured.raw[i] = confSo;
        end
        confShift <= 1'b0;
        outWord = captured;
    endtask

    task automatic loadConf();
        confLoad <= 1'b1;
        tick();
        confLoad <= 1'b0;
    endtask

    task automatic runTest(input int t);
        int                     base;
        string                  name;
        tConf                   newConf;
        logic [`COLS-1:0]       hitMask;
        int                     hitBcid;
        int                     hold;
        logic                   frz;
        int                     count;
        logic [`BCID_BITS-1:0]  expStamp;
        base = t * Fields;
        if (int'(golden[base]) != t) begin
            abortRun($sformatf("Golden file row %0d is missing or out of order", t));
        end
        name        = testName(t);
        newConf.raw = golden[base + 1][`CONF_BITS-1:0];
        hitMask     = golden[base + 2][`COLS-1:0];
        hitBcid     = int'(golden[base + 3]);
        hold        = int'(golden[base + 4]);
        frz         = golden[base + 5][0];
        count       = int'(golden[base + 6]);

        shiftConf(newConf, readBack);
        checkConf(name, lastConf, readBack);
        lastConf = newConf;
        loadConf();
        gotWords.delete();

        // Wait for the crossing count named in the row
        tick();
        while (edgesSinceReset % (1 << `BCID_BITS) != hitBcid) begin
            tick();
        end
        expStamp = newConf.fields.enTestPattern ? `TEST_STAMP
                                                : toGray(`BCID_BITS'(edgesSinceReset));
        for (int w = 0; w < count; w++) begin
            if (golden[base + 7 + w][`BCID_BITS-1:0] != expStamp) begin
                abortRun($sformatf("Golden stamp of %s word %0d disagrees with the count",
                                   name, w));
            end
        end

        hitIn  <= hitMask;
        freeze <= frz;
        repeat (hold) tick();           // Two edges make a pile-up
        hitIn  <= '0;
        freeze <= 1'b0;
        tick();
        checkHitOr(name, hitMask & newConf.fields.hitOrSel, hitOr);

        while (token) begin
            tick();
        end
        if (gotWords.size() != count) begin
            abortRun($sformatf("Test %s sent %0d words where %0d were expected",
                               name, gotWords.size(), count));
        end
        for (int w = 0; w < count; w++) begin
            checkWord(name, golden[base + 7 + w][`WORD_BITS-1:0], gotWords[w]);
        end
    endtask

    initial begin
        reset_ff    <= 1'b1;
        confSi      <= 1'b0;
        confShift   <= 1'b0;
        confLoad    <= 1'b0;
        confDefault <= 1'b0;
        freeze      <= 1'b0;
        hitIn       <= '0;
        dataReady   <= 1'b0;
        lcgState        = Seed;
        cycleCount      = 0;
        edgesSinceReset = 0;
        lastConf        = defaultConf;    // Chain holds the default after reset
        scrambled.raw   = ~defaultConf.raw;
        $readmemh("readout_golden.txt", golden);

        repeat (8) tick();
        reset_ff <= 1'b0;
        tick();

        for (int t = 0; t < NumTests; t++) begin
            runTest(t);
        end
        gotWords.delete();      // Bus stays quiet during the final shifts

        shiftConf(scrambled, readBack);
        checkConf("final_readback", lastConf, readBack);

        // Chain now far from default, so the reload is visible
        confDefault <= 1'b1;
        tick();
        confDefault <= 1'b0;
        shiftConf(scrambled, readBack);
        checkConf("default_reload", defaultConf, readBack);

        if (gotWords.size() != 0) begin
            abortRun("Words appeared on the bus with no hit pending");
        end

        $display("No errors");
        $finish;
    end

endmodule

//--- readout_golden.txt
// Columns: test, conf, hit mask, bcid, hold, freeze, word count, eight expected words
// bcid is the binary crossing count at the sampling edge, words are {col, stamp}

// One hit in column 3, all columns enabled
00 1FF00 08 05 1 0 1 0C7 000 000 000 000 000 000 000

// One hit in column 0
01 1FF00 01 2C 1 0 1 03A 000 000 000 000 000 000 000

// Every column at once
02 1FF00 FF 10 1 0 8 018 058 098 0D8 118 158 198 1D8

// Scattered columns at the counter wrap point
03 1FF00 A5 3F 1 0 4 020 0A0 160 1E0 000 000 000 000

// Hits only in disabled columns
04 10F00 F0 08 1 0 0 000 000 000 000 000 000 000 000

// Even columns enabled
05 15500 FF 21 1 0 4 031 0B1 131 1B1 000 000 000 000

// Freeze held during the hit
06 1FF00 FF 12 1 1 0 000 000 000 000 000 000 000 000

// Hit held two edges, second one lost
07 1FF00 44 30 2 0 2 0A8 1A8 000 000 000 000 000 000

// Fixed stamp in every word
08 3FF00 81 0A 1 0 2 02A 1EA 000 000 000 000 000 000

// Hit-OR selects overlap the hits
09 1FF3C 18 1B 1 0 2 0D6 116 000 000 000 000 000 000

// Hit-OR selects miss the hits
0A 1FFC3 3C 02 1 0 4 083 0C3 103 143 000 000 000 000

// Test pattern with half the columns masked
0B 3F0F0 3C 33 1 0 2 12A 16A 000 000 000 000 000 000

//--- src.f
+incdir+.
pixelPkg.sv
confRegister.sv
hitCapture.sv
readoutArbiter.sv
pixelCore.sv
tbPixelCore.sv

//--- Makefile
TOP := tbPixelCore

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f src.f --top-module pixelCore
	verilator --lint-only --timing -f src.f --top-module $(TOP)

obj_dir/V$(TOP): src.f $(wildcard *.sv *.svh)
	verilator --binary --timing -f src.f --top-module $(TOP) -o V$(TOP)

# Exit status of the binary is the pass or fail result
sim: obj_dir/V$(TOP) readout_golden.txt
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
